// File: sources.f
+incdir+verif
source/csr_pkg.sv
source/csr_access_unit.sv
source/csr_read_mux.sv
source/csr_status_reg.sv
source/csr_trap_regs.sv
source/csr_irq_regs.sv
source/csr_file.sv
verif/tb_csr_file.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR file testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_csr_file
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_csr_file > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
exit 1

// File: verif/tb_csr_model.svh
// ============================================================
// Shadow model of the machine-mode CSRs, LFSR and error counters
// Included in the body of tb_csr_file, which declares irq_lines
// and tb_hart_id before the include
// ============================================================
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

int          errors = 0;
int          checks = 0;
logic [31:0] lfsr_state = 32'ha007_f71e;  // Fixed seed

// Shadow registers
status_t ref_st;
word_t   ref_mtvec;
word_t   ref_mscratch;
word_t   ref_mepc;
word_t   ref_mcause;
word_t   ref_mtval;
word_t   ref_mie;
word_t   ref_mip_sw;                      // Software part of mip only

localparam word_t irq_bits = 32'h0000_0888;  // Bits 11, 7, 3 owned by hardware

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic word_t rand_bits(int n);
  word_t v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};  // One step per bit
  end
  return v;
endfunction

function automatic void reset_model();
  ref_st       = '{mie: 1'b0, mpie: 1'b0, mpp: priv_machine};
  ref_mtvec    = '0;
  ref_mscratch = '0;
  ref_mepc     = '0;
  ref_mcause   = '0;
  ref_mtval    = '0;
  ref_mie      = '0;
  ref_mip_sw   = '0;
endfunction

function automatic word_t read_expected(csr_addr_t addr);
  case (addr)
    csr_mstatus_addr:   return {19'b0, ref_st.mpp, 3'b0, ref_st.mpie, 3'b0, ref_st.mie, 3'b0};
    csr_misa_addr:      return misa_value;
    csr_mie_addr:       return ref_mie;
    csr_mtvec_addr:     return ref_mtvec;
    csr_mscratch_addr:  return ref_mscratch;
    csr_mepc_addr:      return ref_mepc;
    csr_mcause_addr:    return ref_mcause;
    csr_mtval_addr:     return ref_mtval;
    csr_mip_addr:       return ref_mip_sw | {20'b0, irq_lines.meip, 3'b0, irq_lines.mtip,
                                             3'b0, irq_lines.msip, 3'b0};
    csr_mimpid_addr:    return 32'd1;
    csr_mhartid_addr:   return tb_hart_id;
    default:            return '0;     // Vendor, arch and unknown
  endcase
endfunction

function automatic logic is_illegal(csr_req_t req, priv_t priv);
  logic known;
  logic ro;
  known = req.addr inside {csr_mstatus_addr, csr_misa_addr, csr_mie_addr, csr_mtvec_addr,
                           csr_mscratch_addr, csr_mepc_addr, csr_mcause_addr,
                           csr_mtval_addr, csr_mip_addr, csr_mvendorid_addr,
                           csr_marchid_addr, csr_mimpid_addr, csr_mhartid_addr};
  ro    = (req.addr[11:10] == 2'b11) || (req.addr == csr_misa_addr);
  return req.access && (!known || (req.addr[9:8] > priv) || (req.we && ro));
endfunction

function automatic word_t rmw_value(csr_op_e op, word_t old, word_t wdata);
  case (op)
    csr_rw, csr_rwi: return wdata;
    csr_rs, csr_rsi: return old | wdata;
    csr_rc, csr_rci: return old & ~wdata;
    default:         return old;
  endcase
endfunction

function automatic void commit_write(csr_addr_t addr, word_t data);
  case (addr)
    csr_mstatus_addr: begin
      ref_st.mie  = data[mstatus_mie_bit];
      ref_st.mpie = data[mstatus_mpie_bit];
      ref_st.mpp  = priv_t'(data[mstatus_mpp_lsb +: 2]);
    end
    csr_mie_addr:      ref_mie      = data;
    csr_mtvec_addr:    ref_mtvec    = data & ~tvec_low;  // Base alignment
    csr_mscratch_addr: ref_mscratch = data;
    csr_mepc_addr:     ref_mepc     = data & ~32'h1;
    csr_mcause_addr:   ref_mcause   = data;
    csr_mtval_addr:    ref_mtval    = data;
    csr_mip_addr:      ref_mip_sw   = data & ~irq_bits;
    default: ;
  endcase
endfunction

function automatic void enter_trap(trap_req_t t, priv_t priv);
  ref_mepc    = t.pc;
  ref_mcause  = {t.is_interrupt, 26'b0, t.cause};
  ref_mtval   = t.val;
  ref_st.mpie = ref_st.mie;
  ref_st.mie  = 1'b0;
  ref_st.mpp  = priv;
endfunction

function automatic void return_from_trap();
  ref_st.mie  = ref_st.mpie;
  ref_st.mpie = 1'b1;
  ref_st.mpp  = priv_user;
endfunction

task automatic check_val(string what, word_t got, word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

`endif

// File: verif/tb_csr_file.sv
// ============================================================
// Testbench for the machine-mode CSR file, hart_id 5
// Inputs change on the falling edge, checks run on the rising edge
// Fixed LFSR seed, so every run is the same sequence
// ============================================================
`default_nettype none

module tb_csr_file import csr_pkg::*; ();

  localparam word_t tb_hart_id = 32'd5;
  localparam word_t tvec_low   = 32'h3;  // Two low bits of mtvec forced to zero

  logic       clk;
  logic       reset_n;
  csr_req_t   csr_req;
  priv_t      current_priv;
  logic       trap_entry;
  trap_req_t  trap_req;
  logic       mret;
  irq_lines_t irq_lines;
  irq_lines_t irq_next;   // Applied at the next falling edge
  word_t      csr_rdata;
  logic       illegal_csr;
  word_t      trap_vector;
  word_t      mepc_out;
  status_t    status;
  word_t      mip_out;
  word_t      mie_out;
  logic       chk_en;

  `include "tb_csr_model.svh"

  csr_file #(.hart_id(tb_hart_id), .tvec_align_bits(2)) csr_file_i (
    .clk(clk), .reset_n(reset_n), .csr_req(csr_req), .current_priv(current_priv),
    .csr_rdata(csr_rdata), .illegal_csr(illegal_csr), .trap_entry(trap_entry),
    .trap_req(trap_req), .mret(mret), .irq_lines(irq_lines), .trap_vector(trap_vector),
    .mepc_out(mepc_out), .status(status), .mip_out(mip_out), .mie_out(mie_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================
  // Stimulus helpers
  // ==========================================================
  function automatic csr_req_t make_req(csr_addr_t addr, csr_op_e op, word_t wdata, logic we);
    return '{addr: addr, wdata: wdata, op: op, we: we, access: 1'b1};
  endfunction

  function automatic csr_addr_t rw_target(logic [1:0] sel);
    case (sel)
      2'd0:    return csr_mscratch_addr;
      2'd1:    return csr_mie_addr;
      2'd2:    return csr_mtvec_addr;
      default: return csr_mepc_addr;
    endcase
  endfunction

  function automatic csr_op_e op_from_bits(logic [2:0] sel);
    case (sel)
      3'd0, 3'd6: return csr_rw;
      3'd1, 3'd7: return csr_rs;
      3'd2:       return csr_rc;
      3'd3:       return csr_rwi;
      3'd4:       return csr_rsi;
      default:    return csr_rci;
    endcase
  endfunction

  // One cycle of inputs, set on the falling edge
  task automatic drive_cycle(csr_req_t req, priv_t priv, logic trap, trap_req_t treq,
                             logic ret);
    @(negedge clk);
    csr_req      = req;
    current_priv = priv;
    trap_entry   = trap;
    trap_req     = treq;
    mret         = ret;
    irq_lines    = irq_next;
  endtask

  task automatic read_csr(csr_addr_t addr);
    drive_cycle(make_req(addr, csr_rs, '0, 1'b0), priv_machine, 1'b0, '0, 1'b0);
  endtask

  // ==========================================================
  // Compare and model step on each rising edge
  // ==========================================================
  always @(posedge clk) begin
    word_t exp_rd;
    logic  exp_ill;
    if (chk_en) begin
      exp_rd  = read_expected(csr_req.addr);
      exp_ill = is_illegal(csr_req, current_priv);
      check_val("csr_rdata", csr_rdata, exp_rd);
      check_val("illegal_csr", {31'b0, illegal_csr}, {31'b0, exp_ill});
      check_val("trap_vector", trap_vector, ref_mtvec);
      check_val("mepc_out", mepc_out, ref_mepc);
      check_val("status", {28'b0, status}, {28'b0, ref_st});
      check_val("mip_out", mip_out, read_expected(csr_mip_addr));
      check_val("mie_out", mie_out, ref_mie);
      // Trap beats MRET, MRET beats a write
      if (trap_entry) begin
        enter_trap(trap_req, current_priv);
      end else if (mret) begin
        return_from_trap();
      end else if (csr_req.access && csr_req.we && !exp_ill) begin
        commit_write(csr_req.addr, rmw_value(csr_req.op, exp_rd, csr_req.wdata));
      end
    end
  end

  // Watchdog
  initial begin
    for (int n = 0; n < 2000; n++) begin
      @(posedge clk);
    end
    $display("Timeout: the test sequence did not finish within 2000 cycles");
    $display("TB FAILED");
    $finish;
  end

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    word_t     r;
    word_t     wdata;
    csr_addr_t addr;
    csr_op_e   op;
    trap_req_t treq;
    priv_t     tpriv;
    csr_req      = '0;
    current_priv = priv_machine;
    trap_entry   = 1'b0;
    trap_req     = '0;
    mret         = 1'b0;
    irq_lines    = '0;
    irq_next     = '0;
    chk_en       = 1'b0;
    reset_n      = 1'b0;
    reset_model();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    chk_en  = 1'b1;

    // Reset values and identity registers
    read_csr(csr_mstatus_addr);
    read_csr(csr_misa_addr);
    read_csr(csr_mhartid_addr);
    read_csr(csr_mimpid_addr);

    // Random ops on writable registers, each followed by a read
    for (int i = 0; i < 48; i++) begin
      r    = rand_bits(2);
      addr = rw_target(r[1:0]);
      r    = rand_bits(3);
      op   = op_from_bits(r[2:0]);
      if (op inside {csr_rwi, csr_rsi, csr_rci}) begin
        wdata = rand_bits(5);            // Zero-extended uimm
      end else begin
        wdata = rand_bits(32);
      end
      drive_cycle(make_req(addr, op, wdata, 1'b1), priv_machine, 1'b0, '0, 1'b0);
      read_csr(addr);
    end

    // Illegal accesses
    drive_cycle(make_req(12'h7C0, csr_rw, 32'hFFFF_FFFF, 1'b1), priv_machine, 1'b0, '0, 1'b0);
    drive_cycle(make_req(csr_mstatus_addr, csr_rs, '0, 1'b0), priv_user, 1'b0, '0, 1'b0);
    drive_cycle(make_req(csr_mscratch_addr, csr_rw, 32'h5A5A_5A5A, 1'b1), priv_user, 1'b0,
                '0, 1'b0);
    drive_cycle(make_req(csr_mhartid_addr, csr_rw, 32'h1234, 1'b1), priv_machine, 1'b0, '0,
                1'b0);
    drive_cycle(make_req(csr_misa_addr, csr_rw, '0, 1'b1), priv_machine, 1'b0, '0, 1'b0);
    read_csr(csr_mhartid_addr);
    read_csr(csr_misa_addr);
    read_csr(csr_mscratch_addr);

    // Trap entry and MRET, each with a write that must be dropped
    for (int i = 0; i < 4; i++) begin
      drive_cycle(make_req(csr_mstatus_addr, csr_rsi, 32'h8, 1'b1), priv_machine, 1'b0, '0,
                  1'b0);                 // Set MIE
      tpriv             = i[0] ? priv_user : priv_machine;  // Both modes land in MPP
      treq.pc           = rand_bits(32);
      r                 = rand_bits(6);
      treq.cause        = r[4:0];
      treq.is_interrupt = r[5];
      treq.val          = rand_bits(32);
      drive_cycle(make_req(csr_mscratch_addr, csr_rw, rand_bits(32), 1'b1), tpriv, 1'b1,
                  treq, 1'b0);
      read_csr(csr_mepc_addr);
      read_csr(csr_mcause_addr);
      read_csr(csr_mtval_addr);
      read_csr(csr_mstatus_addr);
      drive_cycle(make_req(csr_mstatus_addr, csr_rw, 32'h0000_1888, 1'b1), priv_machine,
                  1'b0, '0, 1'b1);
      read_csr(csr_mstatus_addr);
      read_csr(csr_mscratch_addr);
    end

    // Hardware lines against software writes to mip
    for (int i = 0; i < 12; i++) begin
      r        = rand_bits(3);
      irq_next = r[2:0];
      drive_cycle(make_req(csr_mip_addr, csr_rw, rand_bits(32), 1'b1), priv_machine, 1'b0,
                  '0, 1'b0);
      read_csr(csr_mip_addr);
    end

    drive_cycle('0, priv_machine, 1'b0, '0, 1'b0);
    @(negedge clk);
    chk_en = 1'b0;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/csr_file.sv
// ============================================================
// Machine-mode CSR file of an RV32 core
// Reads and illegal_csr are same cycle, updates one cycle later
// trap_entry and mret are single-cycle pulses, never together
// ============================================================
`default_nettype none

module csr_file import csr_pkg::*; #(
  parameter word_t hart_id         = '0,
  parameter int    tvec_align_bits = 2
) (
  input  wire             clk,
  input  wire             reset_n,
  input  wire csr_req_t   csr_req,
  input  wire priv_t      current_priv,
  output word_t           csr_rdata,
  output logic            illegal_csr,
  input  wire             trap_entry,
  input  wire trap_req_t  trap_req,
  input  wire             mret,
  input  wire irq_lines_t irq_lines,
  output word_t           trap_vector,  // mtvec
  output word_t           mepc_out,
  output status_t         status,
  output word_t           mip_out,      // Includes live hw lines
  output word_t           mie_out
);

  csr_wr_t wr;          // Committed write
  word_t   status_word;
  word_t   mscratch;
  word_t   mcause;
  word_t   mtval;

  // ==========================================================
  // Decode and read path
  // ==========================================================
  csr_access_unit access_i (
    .csr_req(csr_req), .current_priv(current_priv), .csr_rdata(csr_rdata),
    .trap_entry(trap_entry), .mret(mret), .illegal_csr(illegal_csr), .wr(wr)
  );

  csr_read_mux #(.hart_id(hart_id)) read_mux_i (
    .addr(csr_req.addr), .status_word(status_word), .mtvec(trap_vector),
    .mscratch(mscratch), .mepc(mepc_out), .mcause(mcause), .mtval(mtval),
    .mie(mie_out), .mip(mip_out), .rdata(csr_rdata)
  );

  // ==========================================================
  // Register banks
  // ==========================================================
  csr_status_reg status_i (
    .clk(clk), .reset_n(reset_n), .wr(wr), .trap_entry(trap_entry), .mret(mret),
    .current_priv(current_priv), .status(status), .status_word(status_word)
  );

  csr_trap_regs #(.tvec_align_bits(tvec_align_bits)) trap_regs_i (
    .clk(clk), .reset_n(reset_n), .wr(wr), .trap_entry(trap_entry), .trap_req(trap_req),
    .mtvec(trap_vector), .mscratch(mscratch), .mepc(mepc_out), .mcause(mcause),
    .mtval(mtval)
  );

  csr_irq_regs irq_i (
    .clk(clk), .reset_n(reset_n), .wr(wr), .irq_lines(irq_lines),
    .mie(mie_out), .mip(mip_out)
  );

endmodule

`default_nettype wire

// File: source/csr_irq_regs.sv
// ============================================================
// mie and the software part of mip
// MSIP, MTIP and MEIP come only from irq_lines, as levels
// ============================================================
`default_nettype none

module csr_irq_regs import csr_pkg::*; (
  input  wire             clk,
  input  wire             reset_n,
  input  wire csr_wr_t    wr,
  input  wire irq_lines_t irq_lines,
  output word_t           mie,
  output word_t           mip
);

  word_t mip_sw;  // Software-writable pending bits

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie    <= '0;
      mip_sw <= '0;
    end else if (wr.valid) begin
      if (wr.addr == csr_mie_addr) mie    <= wr.data;
      if (wr.addr == csr_mip_addr) mip_sw <= wr.data & ~mip_hw_mask;  // hw bits dropped
    end
  end

  // Merge live hardware lines
  always_comb begin
    mip               = mip_sw;
    mip[mip_msip_bit] = irq_lines.msip;
    mip[mip_mtip_bit] = irq_lines.mtip;
    mip[mip_meip_bit] = irq_lines.meip;
  end

endmodule

`default_nettype wire

// File: source/csr_trap_regs.sv
// ============================================================
// mtvec, mscratch, mepc, mcause and mtval
// tvec_align_bits must be 1 or 2, mtvec MODE bits read zero
// mepc is kept 2-byte aligned on writes
// ============================================================
`default_nettype none

module csr_trap_regs import csr_pkg::*; #(
  parameter int tvec_align_bits = 2
) (
  input  wire            clk,
  input  wire            reset_n,
  input  wire csr_wr_t   wr,
  input  wire            trap_entry,
  input  wire trap_req_t trap_req,
  output word_t          mtvec,
  output word_t          mscratch,
  output word_t          mepc,
  output word_t          mcause,
  output word_t          mtval
);

  // Bits kept on a write
  localparam word_t tvec_keep = ~word_t'((1 << tvec_align_bits) - 1);
  localparam word_t epc_keep  = ~word_t'(1);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap_entry) begin
      mepc   <= trap_req.pc;
      mcause <= {trap_req.is_interrupt, {(xlen - 6){1'b0}}, trap_req.cause};
      mtval  <= trap_req.val;
    end else if (wr.valid) begin
      case (wr.addr)
        csr_mtvec_addr:    mtvec    <= wr.data & tvec_keep;
        csr_mscratch_addr: mscratch <= wr.data;
        csr_mepc_addr:     mepc     <= wr.data & epc_keep;
        csr_mcause_addr:   mcause   <= wr.data;
        csr_mtval_addr:    mtval    <= wr.data;
        default: ;                               // Not one of ours
      endcase
    end
  end

  // Handler base stays aligned across reset, writes and traps
  assert property (@(posedge clk) disable iff (!reset_n)
                   mtvec[tvec_align_bits-1:0] == '0);

endmodule

`default_nettype wire

// File: source/csr_status_reg.sv
// ============================================================
// mstatus with MIE, MPIE and MPP only, other bits read zero
// MPP written as-is, no WARL legalization of value 2
// trap_entry and mret must never be high in the same cycle
// ============================================================
`default_nettype none

module csr_status_reg import csr_pkg::*; (
  input  wire           clk,
  input  wire           reset_n,
  input  wire csr_wr_t  wr,
  input  wire           trap_entry,
  input  wire           mret,
  input  wire priv_t    current_priv,
  output status_t       status,
  output word_t         status_word
);

  logic wr_hit;

  assign wr_hit = wr.valid && (wr.addr == csr_mstatus_addr);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      status.mie  <= 1'b0;
      status.mpie <= 1'b0;
      status.mpp  <= priv_machine;  // Hart starts in M mode
    end else if (trap_entry) begin
      status.mpie <= status.mie;    // Stack the enable
      status.mie  <= 1'b0;          // Handler runs masked
      status.mpp  <= current_priv;
    end else if (mret) begin
      status.mie  <= status.mpie;
      status.mpie <= 1'b1;
      status.mpp  <= priv_user;     // Least privileged mode
    end else if (wr_hit) begin
      status.mie  <= wr.data[mstatus_mie_bit];
      status.mpie <= wr.data[mstatus_mpie_bit];
      status.mpp  <= priv_t'(wr.data[mstatus_mpp_lsb +: 2]);
    end
  end

  // Architectural view for CSR reads
  always_comb begin
    status_word                          = '0;
    status_word[mstatus_mie_bit]         = status.mie;
    status_word[mstatus_mpie_bit]        = status.mpie;
    status_word[mstatus_mpp_lsb +: 2]    = status.mpp;
  end

  // Core must not retire an MRET in a trap cycle
  assert property (@(posedge clk) disable iff (!reset_n) !(trap_entry && mret));

endmodule

`default_nettype wire

// File: source/csr_read_mux.sv
// ============================================================
// CSR read data select, zero for an unknown address
// hart_id is a design-time constant per hart
// ============================================================
`default_nettype none

module csr_read_mux import csr_pkg::*; #(
  parameter word_t hart_id = '0
) (
  input  wire csr_addr_t addr,
  input  wire word_t     status_word,  // Packed mstatus view
  input  wire word_t     mtvec,
  input  wire word_t     mscratch,
  input  wire word_t     mepc,
  input  wire word_t     mcause,
  input  wire word_t     mtval,
  input  wire word_t     mie,
  input  wire word_t     mip,          // Already merged with hw lines
  output word_t          rdata
);

  // Identity registers
  localparam word_t mvendorid_value = 32'h0000_0000;  // Non-commercial
  localparam word_t marchid_value   = 32'h0000_0000;
  localparam word_t mimpid_value    = 32'h0000_0001;

  always_comb begin
    case (addr)
      csr_mstatus_addr:   rdata = status_word;
      csr_misa_addr:      rdata = misa_value;
      csr_mie_addr:       rdata = mie;
      csr_mtvec_addr:     rdata = mtvec;
      csr_mscratch_addr:  rdata = mscratch;
      csr_mepc_addr:      rdata = mepc;
      csr_mcause_addr:    rdata = mcause;
      csr_mtval_addr:     rdata = mtval;
      csr_mip_addr:       rdata = mip;
      csr_mvendorid_addr: rdata = mvendorid_value;
      csr_marchid_addr:   rdata = marchid_value;
      csr_mimpid_addr:    rdata = mimpid_value;
      csr_mhartid_addr:   rdata = hart_id;
      default:            rdata = '0;  // Legality flagged by the access unit
    endcase
  end

endmodule

`default_nettype wire

// File: source/csr_access_unit.sv
// ============================================================
// Legality check and read-modify-write value for CSR ops
// Purely combinational, result valid in the request cycle
// A write commits only if legal and no trap or MRET is active
// ============================================================
`default_nettype none

module csr_access_unit import csr_pkg::*; (
  input  wire csr_req_t csr_req,
  input  wire priv_t    current_priv,
  input  wire word_t    csr_rdata,     // Old value from the read mux
  input  wire           trap_entry,
  input  wire           mret,
  output logic          illegal_csr,
  output csr_wr_t       wr
);

  logic  exists;
  logic  priv_ok;
  logic  read_only;
  word_t new_value;

  always_comb begin
    // Address decode
    case (csr_req.addr)
      csr_mstatus_addr, csr_misa_addr, csr_mie_addr, csr_mtvec_addr,
      csr_mscratch_addr, csr_mepc_addr, csr_mcause_addr, csr_mtval_addr,
      csr_mip_addr, csr_mvendorid_addr, csr_marchid_addr,
      csr_mimpid_addr, csr_mhartid_addr: exists = 1'b1;
      default:                           exists = 1'b0;
    endcase

    priv_ok   = (csr_req.addr[9:8] <= current_priv);  // Level encoded in 9:8
    read_only = (csr_req.addr[11:10] == 2'b11) ||     // Standard RO range
                (csr_req.addr == csr_misa_addr);      // misa is fixed here

    illegal_csr = csr_req.access &&
                  (!exists || !priv_ok || (csr_req.we && read_only));

    // Read-modify-write
    case (csr_req.op)
      csr_rw,  csr_rwi: new_value = csr_req.wdata;
      csr_rs,  csr_rsi: new_value = csr_rdata | csr_req.wdata;
      csr_rc,  csr_rci: new_value = csr_rdata & ~csr_req.wdata;
      default:          new_value = csr_rdata;  // Undefined funct3, no change
    endcase

    // Trap entry and MRET both suppress the write
    wr.valid = csr_req.access && csr_req.we && !illegal_csr && !trap_entry && !mret;
    wr.addr  = csr_req.addr;
    wr.data  = new_value;
  end

endmodule

`default_nettype wire

// File: source/csr_pkg.sv
// ============================================================
// Shared types and constants of the machine-mode CSR file
// RV32 only, so xlen is fixed at 32
// Only machine mode registers have addresses here
// ============================================================
`default_nettype none

package csr_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;      // CSR data word
  typedef logic [11:0]     csr_addr_t;  // CSR address space
  typedef logic [4:0]      cause_t;     // Trap cause code

  typedef enum logic [1:0] {
    priv_user    = 2'b00,
    priv_super   = 2'b01,
    priv_machine = 2'b11
  } priv_t;

  // Same coding as funct3 of the SYSTEM opcode
  typedef enum logic [2:0] {
    csr_rw  = 3'b001,
    csr_rs  = 3'b010,
    csr_rc  = 3'b011,
    csr_rwi = 3'b101,
    csr_rsi = 3'b110,
    csr_rci = 3'b111
  } csr_op_e;

  // ==========================================================
  // Addresses
  // ==========================================================
  localparam csr_addr_t csr_mstatus_addr   = 12'h300;
  localparam csr_addr_t csr_misa_addr      = 12'h301;
  localparam csr_addr_t csr_mie_addr       = 12'h304;
  localparam csr_addr_t csr_mtvec_addr     = 12'h305;
  localparam csr_addr_t csr_mscratch_addr  = 12'h340;
  localparam csr_addr_t csr_mepc_addr      = 12'h341;
  localparam csr_addr_t csr_mcause_addr    = 12'h342;
  localparam csr_addr_t csr_mtval_addr     = 12'h343;
  localparam csr_addr_t csr_mip_addr       = 12'h344;
  localparam csr_addr_t csr_mvendorid_addr = 12'hF11;
  localparam csr_addr_t csr_marchid_addr   = 12'hF12;
  localparam csr_addr_t csr_mimpid_addr    = 12'hF13;
  localparam csr_addr_t csr_mhartid_addr   = 12'hF14;

  // Bit positions
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;
  localparam int mstatus_mpp_lsb  = 11;  // MPP spans 12:11
  localparam int mip_msip_bit     = 3;
  localparam int mip_mtip_bit     = 7;
  localparam int mip_meip_bit     = 11;

  localparam word_t mip_hw_mask = 32'h0000_0888;  // MEIP, MTIP, MSIP
  localparam word_t misa_value  = 32'h4000_1129;  // MXL=1, I M A F D

  // ==========================================================
  // Bundles
  // ==========================================================
  typedef struct packed {
    csr_addr_t addr;
    word_t     wdata;   // rs1 value or zero-extended uimm
    csr_op_e   op;
    logic      we;      // Instruction writes the CSR
    logic      access;  // CSR instruction active
  } csr_req_t;

  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    word_t     data;
  } csr_wr_t;

  typedef struct packed {
    word_t  pc;
    cause_t cause;
    logic   is_interrupt;
    word_t  val;          // Goes to mtval
  } trap_req_t;

  typedef struct packed {
    logic msip;
    logic mtip;
    logic meip;
  } irq_lines_t;

  typedef struct packed {
    logic  mie;
    logic  mpie;
    priv_t mpp;
  } status_t;

endpackage

`default_nettype wire
